// File: design/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

  localparam int XLEN           = 32;
  localparam int WAYS           = 2;
  localparam int SETS           = 16;
  localparam int WORDS_PER_LINE = 4;  // Also the beats in one burst

  // Address split, tag | index | offset
  localparam int OFFSET_BITS   = 4;
  localparam int INDEX_BITS    = 4;
  localparam int TAG_BITS      = 24;
  localparam int BYTE_BITS     = 2;  // Byte within a word
  localparam int WORD_SEL_BITS = 2;  // Word within a line
  localparam int LINE_BITS     = WORDS_PER_LINE * XLEN;

  // Bits 31:28 of cachable space
  localparam logic [3:0] CACHABLE_TOP = 4'h0;

  // Victim LFSR
  localparam int LFSR_BITS = 8;
  localparam logic [LFSR_BITS-1:0] LFSR_SEED = 8'hA5;  // Never zero

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [XLEN/8-1:0]        be_t;
  typedef logic [XLEN-1:0]          addr_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [INDEX_BITS-1:0]    index_t;
  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;
  typedef logic [LINE_BITS-1:0]     line_t;
  typedef logic [WAYS-1:0]          way_mask_t;  // One-hot

endpackage

`default_nettype wire

// File: design/dcache_bus_pkg.sv
`default_nettype none

package dcache_bus_pkg;

  // One processor request, held by the cache until acked
  typedef struct packed {
    dcache_geom_pkg::addr_t addr;
    logic                   we;
    dcache_geom_pkg::be_t   be;
    dcache_geom_pkg::word_t data;
  } cpu_req_t;

  // One beat on the memory bus, always a full word
  typedef struct packed {
    dcache_geom_pkg::addr_t addr;
    logic                   we;
    dcache_geom_pkg::word_t data;
  } mem_beat_t;

  typedef enum logic [2:0] {
    BURST_NONE,
    BURST_FILL,    // Four reads into the line buffer
    BURST_EVICT,   // Four writes of the victim line
    SINGLE_READ,
    SINGLE_WRITE
  } burst_op_t;

  typedef struct packed {
    burst_op_t              op;
    dcache_geom_pkg::addr_t addr;  // Line aligned for bursts
    dcache_geom_pkg::line_t line;  // Preload of the line buffer
    dcache_geom_pkg::word_t word;  // Single write data
  } burst_cmd_t;

endpackage

`default_nettype wire

// File: design/dcache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tag_store (
  input  wire                             i_clk,
  input  wire                             i_reset,
  input  wire dcache_geom_pkg::index_t    i_index,
  input  wire dcache_geom_pkg::tag_t      i_tag,
  input  wire dcache_geom_pkg::way_mask_t i_tag_we,
  input  wire                             i_dirty,
  input  wire dcache_geom_pkg::way_mask_t i_victim_way,
  output dcache_geom_pkg::way_mask_t      o_way_hit,
  output logic                            o_victim_valid,
  output logic                            o_victim_dirty,
  output dcache_geom_pkg::tag_t           o_victim_tag
);

  dcache_geom_pkg::tag_t             tags   [dcache_geom_pkg::WAYS][dcache_geom_pkg::SETS];
  logic [dcache_geom_pkg::SETS-1:0]  valid  [dcache_geom_pkg::WAYS];
  logic [dcache_geom_pkg::SETS-1:0]  dirty  [dcache_geom_pkg::WAYS];
  dcache_geom_pkg::tag_t             tag_q  [dcache_geom_pkg::WAYS];
  dcache_geom_pkg::way_mask_t        valid_q;
  dcache_geom_pkg::way_mask_t        dirty_q;

  // Tags, write first so a replay sees the new line
  always_ff @(posedge i_clk)
  begin
    for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
    begin
      if (i_tag_we[w])
      begin
        tags[w][i_index] <= i_tag;
        tag_q[w]         <= i_tag;
      end
      else
        tag_q[w] <= tags[w][i_index];
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
      begin
        valid[w] <= '0;
        dirty[w] <= '0;
      end
      valid_q <= '0;
      dirty_q <= '0;
    end
    else
    begin
      for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
      begin
        if (i_tag_we[w])
        begin
          valid[w][i_index] <= 1'b1;
          dirty[w][i_index] <= i_dirty;
          valid_q[w]        <= 1'b1;
          dirty_q[w]        <= i_dirty;
        end
        else
        begin
          valid_q[w] <= valid[w][i_index];
          dirty_q[w] <= dirty[w][i_index];
        end
      end
    end
  end

  always_comb
  begin
    o_victim_valid = 1'b0;
    o_victim_dirty = 1'b0;
    o_victim_tag   = '0;
    for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
    begin
      o_way_hit[w] = valid_q[w] && (tag_q[w] == i_tag);
      if (i_victim_way[w])
      begin
        o_victim_valid = valid_q[w];
        o_victim_dirty = dirty_q[w];
        o_victim_tag   = tag_q[w];
      end
    end
  end

  // A tag must never live in two ways of a set
  single_way_hit: assert property (@(posedge i_clk) disable iff (i_reset) $onehot0(o_way_hit));

endmodule

`default_nettype wire

// File: design/dcache_data_store.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_data_store (
  input  wire                             i_clk,
  input  wire dcache_geom_pkg::index_t    i_index,
  input  wire dcache_geom_pkg::word_sel_t i_offset,
  input  wire dcache_geom_pkg::way_mask_t i_word_we,
  input  wire dcache_geom_pkg::way_mask_t i_line_we,
  input  wire dcache_geom_pkg::be_t       i_be,
  input  wire dcache_geom_pkg::word_t     i_word,
  input  wire dcache_geom_pkg::line_t     i_line,
  input  wire dcache_geom_pkg::way_mask_t i_way_hit,
  input  wire dcache_geom_pkg::way_mask_t i_victim_way,
  output dcache_geom_pkg::word_t          o_rd_word,
  output dcache_geom_pkg::line_t          o_victim_line
);

  dcache_geom_pkg::line_t lines  [dcache_geom_pkg::WAYS][dcache_geom_pkg::SETS];
  dcache_geom_pkg::line_t line_q [dcache_geom_pkg::WAYS];
  dcache_geom_pkg::line_t merged [dcache_geom_pkg::WAYS];

  // Stored line with the enabled bytes of i_word laid over it
  always_comb
  begin
    for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
    begin
      merged[w] = lines[w][i_index];
      for (int b = 0; b < dcache_geom_pkg::XLEN / 8; b++)
        if (i_be[b])
          merged[w][i_offset * dcache_geom_pkg::XLEN + b * 8 +: 8] = i_word[b * 8 +: 8];
    end
  end

  always_ff @(posedge i_clk)
  begin
    for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
    begin
      if (i_line_we[w])
      begin
        lines[w][i_index] <= i_line;
        line_q[w]         <= i_line;  // Write first
      end
      else if (i_word_we[w])
      begin
        lines[w][i_index] <= merged[w];
        line_q[w]         <= merged[w];
      end
      else
        line_q[w] <= lines[w][i_index];
    end
  end

  always_comb
  begin
    o_rd_word     = '0;
    o_victim_line = '0;
    for (int w = 0; w < dcache_geom_pkg::WAYS; w++)
    begin
      if (i_way_hit[w])
        o_rd_word = line_q[w][i_offset * dcache_geom_pkg::XLEN +: dcache_geom_pkg::XLEN];
      if (i_victim_way[w])
        o_victim_line = line_q[w];
    end
  end

endmodule

`default_nettype wire

// File: design/dcache_burst_unit.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_burst_unit (
  input  wire                              i_clk,
  input  wire                              i_reset,
  input  wire                              i_start,
  input  wire dcache_bus_pkg::burst_cmd_t  i_cmd,
  input  wire dcache_geom_pkg::line_t      i_victim_line,
  output logic                             o_done,
  output dcache_geom_pkg::line_t           o_line,
  output dcache_geom_pkg::word_t           o_word,
  output logic                             o_mem_stb,
  output dcache_bus_pkg::mem_beat_t        o_mem_beat,
  input  wire                              i_mem_stall,
  input  wire                              i_mem_ack,
  input  wire dcache_geom_pkg::word_t      i_mem_data
);

  dcache_bus_pkg::burst_op_t                op_q;
  dcache_geom_pkg::addr_t                   base_q;
  dcache_geom_pkg::word_t                   word_q;
  dcache_geom_pkg::line_t                   line_q;  // Victim out or fill in
  logic                                     busy_q;
  logic [dcache_geom_pkg::WORD_SEL_BITS:0]  issue_cnt;  // Can reach four
  dcache_geom_pkg::word_sel_t               ack_cnt;
  dcache_geom_pkg::word_sel_t               last_beat;
  logic                                     is_burst;
  logic                                     fill_ack;

  assign is_burst  = (op_q == dcache_bus_pkg::BURST_FILL) || (op_q == dcache_bus_pkg::BURST_EVICT);
  assign last_beat = is_burst ? dcache_geom_pkg::word_sel_t'(dcache_geom_pkg::WORDS_PER_LINE - 1) : '0;
  assign fill_ack  = busy_q && i_mem_ack && (op_q == dcache_bus_pkg::BURST_FILL);

  assign o_mem_stb = busy_q && (issue_cnt <= {1'b0, last_beat});
  assign o_done    = busy_q && i_mem_ack && (ack_cnt == last_beat);
  assign o_word    = i_mem_data;

  // Beat comes from registers only, so it holds under stall
  always_comb
  begin
    o_mem_beat.we   = (op_q == dcache_bus_pkg::BURST_EVICT) || (op_q == dcache_bus_pkg::SINGLE_WRITE);
    o_mem_beat.addr = base_q;
    o_mem_beat.data = word_q;
    if (is_burst)
    begin
      o_mem_beat.addr[dcache_geom_pkg::OFFSET_BITS-1:dcache_geom_pkg::BYTE_BITS] =
        issue_cnt[dcache_geom_pkg::WORD_SEL_BITS-1:0];
      o_mem_beat.data = line_q[issue_cnt[dcache_geom_pkg::WORD_SEL_BITS-1:0] *
                               dcache_geom_pkg::XLEN +: dcache_geom_pkg::XLEN];
    end
  end

  // Last fill word goes straight through with the done pulse
  always_comb
  begin
    o_line = line_q;
    if (fill_ack)
      o_line[ack_cnt * dcache_geom_pkg::XLEN +: dcache_geom_pkg::XLEN] = i_mem_data;
  end

  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      busy_q    <= 1'b0;
      op_q      <= dcache_bus_pkg::BURST_NONE;
      issue_cnt <= '0;
      ack_cnt   <= '0;
    end
    else if (i_start)
    begin
      busy_q    <= 1'b1;
      op_q      <= i_cmd.op;
      issue_cnt <= '0;
      ack_cnt   <= '0;
    end
    else
    begin
      if (o_mem_stb && !i_mem_stall)
        issue_cnt <= issue_cnt + 1'b1;
      if (busy_q && i_mem_ack)
        ack_cnt <= ack_cnt + 1'b1;  // Acks return in order
      if (o_done)
        busy_q <= 1'b0;
    end
  end

  // A fill overwrites every word, so the victim line is a harmless start value
  always_ff @(posedge i_clk)
  begin
    if (i_start)
    begin
      base_q <= i_cmd.addr;
      word_q <= i_cmd.word;
      line_q <= i_victim_line;
    end
    else if (fill_ack)
      line_q <= o_line;
  end

  beat_held_under_stall: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_mem_stb && i_mem_stall) |=> (o_mem_stb && $stable(o_mem_beat)));

endmodule

`default_nettype wire

// File: design/dcache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
  input  wire                             i_clk,
  input  wire                             i_reset,
  input  wire                             i_wb_stb,
  input  wire dcache_bus_pkg::cpu_req_t   i_wb_req,
  output logic                            o_wb_stall,
  output logic                            o_wb_ack,
  output dcache_geom_pkg::word_t          o_wb_data,
  input  wire dcache_geom_pkg::way_mask_t i_way_hit,
  input  wire                             i_victim_valid,
  input  wire                             i_victim_dirty,
  input  wire dcache_geom_pkg::tag_t      i_victim_tag,
  input  wire dcache_geom_pkg::word_t     i_rd_word,
  output dcache_geom_pkg::index_t         o_index,
  output dcache_geom_pkg::way_mask_t      o_tag_we,
  output logic                            o_tag_dirty,
  output dcache_geom_pkg::way_mask_t      o_data_word_we,
  output dcache_geom_pkg::way_mask_t      o_data_line_we,
  output dcache_geom_pkg::be_t            o_wr_be,
  output dcache_geom_pkg::word_t          o_wr_word,
  output dcache_geom_pkg::line_t          o_fill_line,
  output dcache_geom_pkg::way_mask_t      o_victim_way,
  output logic                            o_burst_start,
  output dcache_bus_pkg::burst_cmd_t      o_burst_cmd,
  input  wire                             i_burst_done,
  input  wire dcache_geom_pkg::line_t     i_fill_line,
  input  wire dcache_geom_pkg::word_t     i_single_word,
  output dcache_geom_pkg::word_t          o_cache_hits,
  output dcache_geom_pkg::word_t          o_cache_misses
);

  typedef enum logic [2:0] {IDLE, LOOKUP, EVICT, FILL, DIRECT, DONE} state_t;

  state_t                                state;
  dcache_bus_pkg::cpu_req_t              req_q;
  dcache_geom_pkg::way_mask_t            victim_q;
  dcache_geom_pkg::word_t                rdata_q;
  logic [dcache_geom_pkg::LFSR_BITS-1:0] lfsr;
  logic                                  replay_q;  // Lookup after a fill
  logic                                  start_q;
  logic                                  hit;
  logic                                  cachable;

  assign hit      = |i_way_hit;
  assign cachable = (i_wb_req.addr[dcache_geom_pkg::XLEN-1 -: 4] == dcache_geom_pkg::CACHABLE_TOP);

  // Free running, so the victim depends on request timing
  always_ff @(posedge i_clk)
  begin
    if (i_reset)
      lfsr <= dcache_geom_pkg::LFSR_SEED;
    else
      lfsr <= {lfsr[dcache_geom_pkg::LFSR_BITS-2:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
  end

  always_ff @(posedge i_clk)
  begin
    if (i_reset)
    begin
      state          <= IDLE;
      start_q        <= 1'b0;
      replay_q       <= 1'b0;
      o_cache_hits   <= '0;
      o_cache_misses <= '0;
    end
    else
    begin
      start_q <= 1'b0;
      case (state)
        IDLE:
          if (i_wb_stb)
          begin
            replay_q <= 1'b0;
            if (cachable)
              state <= LOOKUP;
            else
            begin
              state          <= DIRECT;
              start_q        <= 1'b1;
              o_cache_misses <= o_cache_misses + 1'b1;  // Uncached always misses
            end
          end
        LOOKUP:
        begin
          if (!replay_q && hit)
            o_cache_hits <= o_cache_hits + 1'b1;
          else if (!replay_q)
            o_cache_misses <= o_cache_misses + 1'b1;
          if (hit)
            state <= IDLE;
          else
          begin
            state   <= (i_victim_valid && i_victim_dirty) ? EVICT : FILL;
            start_q <= 1'b1;
          end
        end
        EVICT:
          if (i_burst_done)
          begin
            state   <= FILL;
            start_q <= 1'b1;
          end
        FILL:
          if (i_burst_done)
          begin
            state    <= LOOKUP;
            replay_q <= 1'b1;
          end
        DIRECT:
          if (i_burst_done)
            state <= DONE;
        default: state <= IDLE;  // DONE acks for one cycle
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (state == IDLE && i_wb_stb)
    begin
      req_q    <= i_wb_req;
      victim_q <= dcache_geom_pkg::way_mask_t'(1) << lfsr[0];
    end
    if (state == DIRECT && i_burst_done)
      rdata_q <= i_single_word;
  end

  // Store strobes
  always_comb
  begin
    o_tag_we       = '0;
    o_data_word_we = '0;
    o_data_line_we = '0;
    if (state == LOOKUP && hit && req_q.we)
    begin
      o_tag_we       = i_way_hit;  // Sets dirty
      o_data_word_we = i_way_hit;
    end
    if (state == FILL && i_burst_done)
    begin
      o_tag_we       = victim_q;
      o_data_line_we = victim_q;
    end
  end

  // The command address also feeds the tag compare and word offset
  always_comb
  begin
    o_burst_cmd      = '0;
    o_burst_cmd.op   = dcache_bus_pkg::BURST_NONE;
    o_burst_cmd.addr = req_q.addr;
    o_burst_cmd.word = req_q.data;
    case (state)
      EVICT:
      begin
        o_burst_cmd.op   = dcache_bus_pkg::BURST_EVICT;
        o_burst_cmd.addr = {i_victim_tag, o_index, {dcache_geom_pkg::OFFSET_BITS{1'b0}}};
      end
      FILL:
      begin
        o_burst_cmd.op   = dcache_bus_pkg::BURST_FILL;
        o_burst_cmd.addr[dcache_geom_pkg::OFFSET_BITS-1:0] = '0;
      end
      DIRECT:
        o_burst_cmd.op = req_q.we ? dcache_bus_pkg::SINGLE_WRITE : dcache_bus_pkg::SINGLE_READ;
      default: ;
    endcase
  end

  // New request index in IDLE so the stores answer in LOOKUP
  assign o_index = (state == IDLE)
                 ? i_wb_req.addr[dcache_geom_pkg::OFFSET_BITS +: dcache_geom_pkg::INDEX_BITS]
                 : req_q.addr[dcache_geom_pkg::OFFSET_BITS +: dcache_geom_pkg::INDEX_BITS];

  assign o_tag_dirty   = (state == LOOKUP);  // Clean after a fill
  assign o_wr_be       = req_q.be;
  assign o_wr_word     = req_q.data;
  assign o_fill_line   = i_fill_line;
  assign o_victim_way  = victim_q;
  assign o_burst_start = start_q;

  assign o_wb_stall = (state != IDLE);
  assign o_wb_ack   = (state == LOOKUP && hit) || (state == DONE);
  assign o_wb_data  = (state == DONE) ? rdata_q : i_rd_word;

  // The burst unit only finishes work that was started for it
  done_only_when_waiting: assert property (@(posedge i_clk) disable iff (i_reset)
    i_burst_done |-> (state == EVICT || state == FILL || state == DIRECT));

endmodule

`default_nettype wire

// File: design/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire                           i_wb_stb,
  input  wire dcache_bus_pkg::cpu_req_t i_wb_req,
  output logic                          o_wb_stall,
  output logic                          o_wb_ack,
  output dcache_geom_pkg::word_t        o_wb_data,
  output logic                          o_mem_stb,
  output dcache_bus_pkg::mem_beat_t     o_mem_beat,
  input  wire                           i_mem_stall,
  input  wire                           i_mem_ack,
  input  wire dcache_geom_pkg::word_t   i_mem_data,
  output dcache_geom_pkg::word_t        o_cache_hits,
  output dcache_geom_pkg::word_t        o_cache_misses
);

  dcache_geom_pkg::way_mask_t way_hit, tag_we, data_word_we, data_line_we, victim_way;
  dcache_geom_pkg::index_t    index;
  dcache_geom_pkg::tag_t      victim_tag;
  dcache_geom_pkg::word_t     rd_word, wr_word, single_word;
  dcache_geom_pkg::be_t       wr_be;
  dcache_geom_pkg::line_t     fill_line, burst_line, victim_line;
  dcache_bus_pkg::burst_cmd_t burst_cmd;
  logic                       victim_valid, victim_dirty, tag_dirty, burst_start, burst_done;

  dcache_ctrl ctrl_i (
    .i_clk, .i_reset, .i_wb_stb, .i_wb_req, .o_wb_stall, .o_wb_ack, .o_wb_data,
    .i_way_hit(way_hit), .i_victim_valid(victim_valid), .i_victim_dirty(victim_dirty),
    .i_victim_tag(victim_tag), .i_rd_word(rd_word), .o_index(index), .o_tag_we(tag_we),
    .o_tag_dirty(tag_dirty), .o_data_word_we(data_word_we), .o_data_line_we(data_line_we),
    .o_wr_be(wr_be), .o_wr_word(wr_word), .o_fill_line(fill_line), .o_victim_way(victim_way),
    .o_burst_start(burst_start), .o_burst_cmd(burst_cmd), .i_burst_done(burst_done),
    .i_fill_line(burst_line), .i_single_word(single_word), .o_cache_hits, .o_cache_misses
  );

  // Lookup tag and word offset ride on the command address
  dcache_tag_store tag_store_i (
    .i_clk, .i_reset, .i_index(index),
    .i_tag(burst_cmd.addr[dcache_geom_pkg::XLEN-1 -: dcache_geom_pkg::TAG_BITS]),
    .i_tag_we(tag_we), .i_dirty(tag_dirty), .i_victim_way(victim_way), .o_way_hit(way_hit),
    .o_victim_valid(victim_valid), .o_victim_dirty(victim_dirty), .o_victim_tag(victim_tag)
  );

  dcache_data_store data_store_i (
    .i_clk, .i_index(index),
    .i_offset(burst_cmd.addr[dcache_geom_pkg::OFFSET_BITS-1:dcache_geom_pkg::BYTE_BITS]),
    .i_word_we(data_word_we), .i_line_we(data_line_we), .i_be(wr_be), .i_word(wr_word),
    .i_line(fill_line), .i_way_hit(way_hit), .i_victim_way(victim_way), .o_rd_word(rd_word),
    .o_victim_line(victim_line)
  );

  dcache_burst_unit burst_unit_i (
    .i_clk, .i_reset, .i_start(burst_start), .i_cmd(burst_cmd), .i_victim_line(victim_line),
    .o_done(burst_done), .o_line(burst_line), .o_word(single_word), .o_mem_stb, .o_mem_beat,
    .i_mem_stall, .i_mem_ack, .i_mem_data
  );

endmodule

`default_nettype wire

// File: test/dcache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_mem_model (
  input  wire                            i_clk,
  input  wire                            i_reset,
  input  wire                            i_stb,
  input  wire dcache_bus_pkg::mem_beat_t i_beat,
  output logic                           o_stall,
  output logic                           o_ack,
  output dcache_geom_pkg::word_t         o_data
);

  logic [7:0]                mem [dcache_geom_pkg::addr_t];  // Golden bytes, only those written
  logic                      issued;
  dcache_bus_pkg::mem_beat_t beat;

  // Unwritten bytes follow a pattern of the whole address
  function automatic logic [7:0] byte_at(dcache_geom_pkg::addr_t a);
    if (mem.exists(a))
      return mem[a];
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h96;
  endfunction

  function automatic dcache_geom_pkg::word_t peek_word(dcache_geom_pkg::addr_t a);
    dcache_geom_pkg::word_t w;
    for (int i = 0; i < 4; i++)
      w[i*8 +: 8] = byte_at({a[31:2], 2'b00} + dcache_geom_pkg::addr_t'(i));
    return w;
  endfunction

  initial
  begin
    o_stall = 1'b0;
    o_ack   = 1'b0;
    o_data  = '0;
    issued  = 1'b0;
  end

  // The beat and stall are settled by the falling edge
  always @(negedge i_clk)
  begin
    issued = i_stb && !o_stall && !i_reset;
    beat   = i_beat;
  end

  always @(posedge i_clk)
  begin
    #1;
    o_ack = issued;  // One cycle after the beat
    if (issued && beat.we)
    begin
      for (int i = 0; i < 4; i++)
        mem[{beat.addr[31:2], 2'b00} + dcache_geom_pkg::addr_t'(i)] = beat.data[i*8 +: 8];
    end
    o_data  = (issued && !beat.we) ? peek_word(beat.addr) : '0;
    o_stall = ($urandom % 4 == 0);
  end

endmodule

`default_nettype wire

// File: test/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

  localparam int RAND_REQS    = 200;
  localparam int NUM_REQUESTS = 2 + 2 + 6 + 3 + RAND_REQS;
  localparam int CYCLE_LIMIT  = 40 * NUM_REQUESTS + 16;  // Requests plus reset

  logic                      clk;
  logic                      reset;
  logic                      wb_stb;
  dcache_bus_pkg::cpu_req_t  wb_req;
  logic                      wb_stall;
  logic                      wb_ack;
  dcache_geom_pkg::word_t    wb_data;
  logic                      mem_stb;
  dcache_bus_pkg::mem_beat_t mem_beat;
  logic                      mem_stall;
  logic                      mem_ack;
  dcache_geom_pkg::word_t    mem_data;
  dcache_geom_pkg::word_t    cache_hits;
  dcache_geom_pkg::word_t    cache_misses;

  dcache_geom_pkg::word_t    shadow [dcache_geom_pkg::addr_t];  // Memory as the processor sees it
  dcache_bus_pkg::cpu_req_t  cur_req;
  logic                      req_pending;
  int                        acked, beats, cycles;
  int                        errors, mon_errors, mon_checks, checks, tests, failed_tests;

  dcache_top dut_i (
    .i_clk(clk), .i_reset(reset), .i_wb_stb(wb_stb), .i_wb_req(wb_req),
    .o_wb_stall(wb_stall), .o_wb_ack(wb_ack), .o_wb_data(wb_data),
    .o_mem_stb(mem_stb), .o_mem_beat(mem_beat), .i_mem_stall(mem_stall),
    .i_mem_ack(mem_ack), .i_mem_data(mem_data),
    .o_cache_hits(cache_hits), .o_cache_misses(cache_misses)
  );

  dcache_mem_model mem_i (
    .i_clk(clk), .i_reset(reset), .i_stb(mem_stb), .i_beat(mem_beat),
    .o_stall(mem_stall), .o_ack(mem_ack), .o_data(mem_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic dcache_geom_pkg::word_t fill_word(dcache_geom_pkg::addr_t a);
    dcache_geom_pkg::word_t w;
    dcache_geom_pkg::addr_t b;
    for (int i = 0; i < 4; i++)
    begin
      b = a + dcache_geom_pkg::addr_t'(i);
      w[i*8 +: 8] = b[7:0] ^ b[15:8] ^ b[23:16] ^ b[31:24] ^ 8'h96;
    end
    return w;
  endfunction

  // Expected read data
  function automatic dcache_geom_pkg::word_t ref_read(dcache_geom_pkg::addr_t a);
    dcache_geom_pkg::addr_t wa;
    wa = {a[31:2], 2'b00};
    if (shadow.exists(wa))
      return shadow[wa];
    return fill_word(wa);
  endfunction

  function automatic dcache_geom_pkg::word_t merge_bytes(dcache_geom_pkg::word_t old_w,
                                                         dcache_geom_pkg::word_t wdata,
                                                         dcache_geom_pkg::be_t be);
    dcache_geom_pkg::word_t w;
    w = old_w;
    for (int b = 0; b < 4; b++)
      if (be[b])
        w[b*8 +: 8] = wdata[b*8 +: 8];
    return w;
  endfunction

  task automatic check_word(input string name, input dcache_geom_pkg::addr_t a,
                            input dcache_geom_pkg::word_t got,
                            input dcache_geom_pkg::word_t exp);
    mon_checks++;
    if (got !== exp)
    begin
      mon_errors++;
      $display("** Error: %s at %h: got %h, expected %h", name, a, got, exp);
    end
  endtask

  // Compares every acked read and every memory write beat
  always @(negedge clk)
  begin
    if (!reset)
    begin
      if (mem_stb && !mem_stall)
      begin
        beats++;
        if (mem_beat.we && mem_beat.addr[31:28] == dcache_geom_pkg::CACHABLE_TOP)
          check_word("o_mem_beat.data", mem_beat.addr, mem_beat.data, ref_read(mem_beat.addr));
        else if (mem_beat.we)
          check_word("o_mem_beat.data", mem_beat.addr, mem_beat.data, cur_req.data);
      end
      if (wb_ack)
      begin
        if (!req_pending)
        begin
          mon_errors++;
          $display("Ack seen with no request in flight");
        end
        else if (cur_req.we)
          shadow[{cur_req.addr[31:2], 2'b00}] = merge_bytes(ref_read(cur_req.addr),
                                                            cur_req.data, cur_req.be);
        else
          check_word("o_wb_data", cur_req.addr, wb_data, ref_read(cur_req.addr));
        req_pending = 1'b0;
        acked++;
      end
    end
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles > CYCLE_LIMIT)
    begin
      $display("Timeout: the tests did not end within %0d cycles", CYCLE_LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic send_request(input dcache_geom_pkg::addr_t a, input logic we,
                              input dcache_geom_pkg::be_t be, input dcache_geom_pkg::word_t d);
    @(posedge clk);
    #1;
    if (wb_stall)
    begin
      errors++;
      $display("Cache still stalled when a new request at %h was offered", a);
    end
    wb_req.addr = a;
    wb_req.we   = we;
    wb_req.be   = be;
    wb_req.data = d;
    wb_stb      = 1'b1;
    cur_req     = wb_req;
    req_pending = 1'b1;
    @(posedge clk);
    #1;
    wb_stb = 1'b0;
    @(negedge clk);
    while (!wb_ack)
      @(negedge clk);
  endtask

  // Counters move on the edge after the ack
  task automatic check_counts(input dcache_geom_pkg::word_t exp_hits,
                              input dcache_geom_pkg::word_t exp_misses);
    @(negedge clk);
    checks += 2;
    if (cache_hits !== exp_hits)
    begin
      errors++;
      $display("** Error: o_cache_hits: got %h, expected %h", cache_hits, exp_hits);
    end
    if (cache_misses !== exp_misses)
    begin
      errors++;
      $display("** Error: o_cache_misses: got %h, expected %h", cache_misses, exp_misses);
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors + mon_errors == errs_before)
      $display("test %s: done", name);
    else
    begin
      failed_tests++;
      $display("test %s: %0d errors", name, errors + mon_errors - errs_before);
    end
  endtask

  task automatic test_read_miss_hit();
    int                     errs;
    dcache_geom_pkg::word_t h0;
    dcache_geom_pkg::word_t m0;
    @(negedge clk);
    errs = errors + mon_errors;
    h0   = cache_hits;
    m0   = cache_misses;
    send_request(32'h0000_0100, 1'b0, 4'hF, '0);
    check_counts(h0, m0 + 1);
    send_request(32'h0000_0100, 1'b0, 4'hF, '0);
    check_counts(h0 + 1, m0 + 1);
    finish_test("read miss then hit", errs);
  endtask

  task automatic test_byte_write();
    int                     errs;
    dcache_geom_pkg::word_t h0;
    dcache_geom_pkg::word_t m0;
    @(negedge clk);
    errs = errors + mon_errors;
    h0   = cache_hits;
    m0   = cache_misses;
    send_request(32'h0000_0104, 1'b1, 4'b0110, 32'hDEAD_BEEF);
    send_request(32'h0000_0104, 1'b0, 4'hF, '0);
    check_counts(h0 + 2, m0);
    finish_test("byte enable write", errs);
  endtask

  task automatic test_eviction();
    int                     errs;
    int                     held;
    dcache_geom_pkg::addr_t a;
    @(negedge clk);
    errs = errors + mon_errors;
    held = 0;
    // Tags 1, 2 and 3 all in set 5
    for (int t = 1; t <= 3; t++)
      send_request(dcache_geom_pkg::addr_t'(t << 8) | 32'h58, 1'b1, 4'hF, 32'hC0DE_0000 + t);
    for (int t = 1; t <= 3; t++)
      send_request(dcache_geom_pkg::addr_t'(t << 8) | 32'h58, 1'b0, 4'hF, '0);
    for (int t = 1; t <= 3; t++)
    begin
      a = dcache_geom_pkg::addr_t'(t << 8) | 32'h58;
      if (mem_i.peek_word(a) === 32'hC0DE_0000 + t)
        held++;
    end
    checks++;
    if (held == 0)
    begin
      errors++;
      $display("No evicted line of set 5 reached the memory model");
    end
    finish_test("eviction", errs);
  endtask

  task automatic uncached_access(input dcache_geom_pkg::addr_t a, input logic we,
                                 input dcache_geom_pkg::word_t d);
    dcache_geom_pkg::word_t h0;
    dcache_geom_pkg::word_t m0;
    int                     beats0;
    @(negedge clk);
    h0     = cache_hits;
    m0     = cache_misses;
    beats0 = beats;
    send_request(a, we, 4'hF, d);
    check_counts(h0, m0 + 1);
    checks++;
    if (beats - beats0 != 1)
    begin
      errors++;
      $display("Uncached access at %h took %0d memory beats", a, beats - beats0);
    end
  endtask

  task automatic test_uncached();
    int errs;
    errs = errors + mon_errors;
    uncached_access(32'h8000_0040, 1'b0, '0);
    uncached_access(32'h8000_0044, 1'b1, 32'h1234_5678);
    uncached_access(32'h8000_0044, 1'b0, '0);
    finish_test("non-cachable access", errs);
  endtask

  task automatic test_random_traffic();
    int                     errs;
    dcache_geom_pkg::addr_t a;
    dcache_geom_pkg::be_t   be;
    logic                   we;
    errs = errors + mon_errors;
    for (int n = 0; n < RAND_REQS; n++)
    begin
      a  = dcache_geom_pkg::addr_t'($urandom % 1024) & 32'h0000_03FC;
      be = dcache_geom_pkg::be_t'($urandom % 15 + 1);
      we = ($urandom % 2 == 1);
      if ($urandom % 8 == 0)
      begin
        a  = a | 32'h9000_0000;
        be = 4'hF;  // Uncached writes are whole words
      end
      send_request(a, we, be, $urandom);
    end
    @(negedge clk);
    checks++;
    if (cache_hits + cache_misses != dcache_geom_pkg::word_t'(acked))
    begin
      errors++;
      $display("Hits plus misses is %0d but %0d requests were acked",
               cache_hits + cache_misses, acked);
    end
    finish_test("random traffic", errs);
  endtask

  initial
  begin
    void'($urandom(27));
    reset        = 1'b1;
    wb_stb       = 1'b0;
    wb_req       = '0;
    cur_req      = '0;
    req_pending  = 1'b0;
    acked        = 0;
    beats        = 0;
    cycles       = 0;
    errors       = 0;
    mon_errors   = 0;
    mon_checks   = 0;
    checks       = 0;
    tests        = 0;
    failed_tests = 0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    test_read_miss_hit();
    test_byte_write();
    test_eviction();
    test_uncached();
    test_random_traffic();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks + mon_checks, errors + mon_errors);
    if (errors + mon_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
design/dcache_geom_pkg.sv
design/dcache_bus_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_burst_unit.sv
design/dcache_ctrl.sv
design/dcache_top.sv
test/dcache_mem_model.sv
test/dcache_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module dcache_tb -o dcache_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log
grep -qx '\*\* PASS \*\*' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
